// ==== all.f ====
+incdir+verification
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/branch_unit.sv
logic/decode_stage.sv
verification/decode_tb.sv

// ==== Makefile ====
# Verilator build and run of the decode stage testbench

SIM       ?= verilator
TOP       ?= decode_tb
# 956173832 is 32'h38fe_0e08
SEED      ?= 956173832
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(VFLAGS) --top-module $(TOP) -Gseed_init=$(SEED) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# $fatal in the testbench gives a non-zero exit status
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/decode_ref.svh ====
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// shadow copy of the architectural registers
word_t shadow [32];

// r0 reads zero, a same-cycle write is seen by the read
function automatic word_t shadow_read(input reg_addr_t addr, input wb_t w);
    if (addr == 5'd0)
        return 32'd0;
    if (w.we && (w.addr == addr))
        return w.data;
    return shadow[addr];
endfunction

// name of the instruction from its opcode bits
function automatic string mnemonic(input word_t inst);
    string n;
    casez (inst[31:15])
        17'h00020:               n = "add.w";
        17'h00022:               n = "sub.w";
        17'h00024:               n = "slt";
        17'h00025:               n = "sltu";
        17'h00028:               n = "nor";
        17'h00029:               n = "and";
        17'h0002a:               n = "or";
        17'h0002b:               n = "xor";
        17'h0002e:               n = "sll.w";
        17'h0002f:               n = "srl.w";
        17'h00030:               n = "sra.w";
        17'h00081:               n = "slli.w";
        17'h00089:               n = "srli.w";
        17'h00091:               n = "srai.w";
        17'b0000001000_???????:  n = "slti";
        17'b0000001001_???????:  n = "sltui";
        17'b0000001010_???????:  n = "addi.w";
        17'b0000001101_???????:  n = "andi";
        17'b0000001110_???????:  n = "ori";
        17'b0000001111_???????:  n = "xori";
        17'b0001010_??????????:  n = "lu12i.w";
        17'b0001110_??????????:  n = "pcaddu12i";
        17'b010011_???????????:  n = "jirl";
        17'b010100_???????????:  n = "b";
        17'b010101_???????????:  n = "bl";
        17'b010110_???????????:  n = "beq";
        17'b010111_???????????:  n = "bne";
        17'b011000_???????????:  n = "blt";
        17'b011001_???????????:  n = "bge";
        17'b011010_???????????:  n = "bltu";
        17'b011011_???????????:  n = "bgeu";
        default:                 n = "invalid";
    endcase
    return n;
endfunction

// expected bundle to execute
function automatic ds_to_es_t expect_bundle(input word_t pc, input word_t inst, input wb_t w);
    ds_to_es_t e;
    string     n;
    logic      cond;
    n = mnemonic(inst);
    cond = n inside {"beq", "bne", "blt", "bge", "bltu", "bgeu"};
    e = '0;
    e.pc = pc;
    e.dest = (n == "bl") ? 5'd1 : inst[4:0];
    e.rj_value = shadow_read(inst[9:5], w);
    // conditional branches compare against rd
    e.rkd_value = shadow_read(cond ? inst[4:0] : inst[14:10], w);
    if (n inside {"bl", "jirl"})
        e.imm = 32'd4;
    else if (n inside {"lu12i.w", "pcaddu12i"})
        e.imm = {inst[24:5], 12'b0};
    else if (n inside {"slli.w", "srli.w", "srai.w"})
        e.imm = {27'b0, inst[14:10]};
    else if (n inside {"addi.w", "slti", "sltui"})
        e.imm = {{20{inst[21]}}, inst[21:10]};
    else if (n inside {"andi", "ori", "xori"})
        e.imm = {20'b0, inst[21:10]};
    e.op.alu_op.add     = n inside {"add.w", "addi.w", "pcaddu12i", "bl", "jirl"};
    e.op.alu_op.sub     = (n == "sub.w");
    e.op.alu_op.slt     = n inside {"slt", "slti"};
    e.op.alu_op.sltu    = n inside {"sltu", "sltui"};
    e.op.alu_op.bit_and = n inside {"and", "andi"};
    e.op.alu_op.bit_nor = (n == "nor");
    e.op.alu_op.bit_or  = n inside {"or", "ori"};
    e.op.alu_op.bit_xor = n inside {"xor", "xori"};
    e.op.alu_op.sll     = n inside {"sll.w", "slli.w"};
    e.op.alu_op.srl     = n inside {"srl.w", "srli.w"};
    e.op.alu_op.sra     = n inside {"sra.w", "srai.w"};
    e.op.alu_op.lui     = (n == "lu12i.w");
    e.op.src1_is_pc     = n inside {"pcaddu12i", "bl", "jirl"};
    e.op.src2_is_imm    = (e.imm != 32'd0) || n inside {"slli.w", "srli.w", "srai.w",
        "addi.w", "slti", "sltui", "andi", "ori", "xori", "lu12i.w", "pcaddu12i"};
    e.op.ine            = (n == "invalid");
    e.op.gr_we          = !e.op.ine && !cond && (n != "b");
    case (n)
        "beq":   e.op.br_kind = br_beq;
        "bne":   e.op.br_kind = br_bne;
        "blt":   e.op.br_kind = br_blt;
        "bge":   e.op.br_kind = br_bge;
        "bltu":  e.op.br_kind = br_bltu;
        "bgeu":  e.op.br_kind = br_bgeu;
        "b":     e.op.br_kind = br_b;
        "bl":    e.op.br_kind = br_bl;
        "jirl":  e.op.br_kind = br_jirl;
        default: e.op.br_kind = br_none;
    endcase
    return e;
endfunction

// taken flag and target of a branch in decode
function automatic br_t expect_branch(input word_t pc, input word_t inst,
                                      input word_t a, input word_t b);
    br_t   r;
    string n;
    word_t offs16;
    word_t offs26;
    n = mnemonic(inst);
    offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    case (n)
        "beq":               r.taken = (a == b);
        "bne":               r.taken = (a != b);
        "blt":               r.taken = ($signed(a) < $signed(b));
        "bge":               r.taken = ($signed(a) >= $signed(b));
        "bltu":              r.taken = (a < b);
        "bgeu":              r.taken = (a >= b);
        "b", "bl", "jirl":   r.taken = 1'b1;
        default:             r.taken = 1'b0;
    endcase
    if (n == "jirl")
        r.target = a + offs16;
    else if (n inside {"b", "bl"})
        r.target = pc + offs26;
    else
        r.target = pc + offs16;
    return r;
endfunction

`endif

// ==== verification/decode_tb.sv ====
module decode_tb
    import isa_pkg::*;
    import pipe_pkg::*;
#(
    parameter int seed_init = 32'h38fe_0e08
)();

    localparam int wait_limit = 200;

    logic      clk;
    logic      reset;
    logic      fs_valid;
    fs_to_ds_t fs_bus;
    logic      es_allow_in = 1'b1;
    wb_t       wb = '0;
    logic      ds_allow_in;
    logic      es_valid;
    ds_to_es_t es_bus;
    br_t       br;

    integer      seed;
    string       test_name;
    logic        stall_random = 1'b0;
    logic        wb_random = 1'b0;
    logic [31:0] wb_bits;
    // walks r1..r31 once so no register reads as unknown
    reg_addr_t   preload_addr = 5'd1;
    word_t       next_pc;
    // instructions accepted by decode, oldest first
    fs_to_ds_t   pending [$];
    int          transferred = 0;
    // wrong-path offers in a taken branch cycle
    int          dropped = 0;

    `include "decode_ref.svh"

    decode_stage u_dut (
        .clk         (clk),
        .reset       (reset),
        .fs_valid    (fs_valid),
        .fs_bus      (fs_bus),
        .ds_allow_in (ds_allow_in),
        .es_valid    (es_valid),
        .es_bus      (es_bus),
        .es_allow_in (es_allow_in),
        .wb          (wb),
        .br          (br)
    );

    always #2 clk = ~clk;

    task automatic report_error(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual)
            report_error($sformatf("mismatch %s %s expected %h actual %h",
                                   test_name, what, expected, actual));
    endtask

    // small register range half the time, so bypass hits are frequent
    function automatic reg_addr_t pick_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[3] ? {2'b00, r[2:0]} : r[8:4];
    endfunction

    function automatic logic [4:0] reg_op5(input int idx);
        case (idx)
            0:       return 5'h00;
            1:       return 5'h02;
            2:       return 5'h04;
            3:       return 5'h05;
            4:       return 5'h08;
            5:       return 5'h09;
            6:       return 5'h0a;
            7:       return 5'h0b;
            8:       return 5'h0e;
            9:       return 5'h0f;
            default: return 5'h10;
        endcase
    endfunction

    // group 0 register alu, 1 immediate, 2 branch, 3 undefined
    function automatic word_t random_inst(input int group);
        logic [31:0] r;
        logic [31:0] f;
        int          idx;
        r = $random(seed);
        f = $random(seed);
        idx = int'(r[7:0]);
        case (group)
            0:
                return {12'h001, reg_op5(idx % 11), pick_reg(), pick_reg(), pick_reg()};
            1:
            begin
                case (idx % 11)
                    0:       return {10'h00a, f[11:0], pick_reg(), pick_reg()};
                    1:       return {10'h008, f[11:0], pick_reg(), pick_reg()};
                    2:       return {10'h009, f[11:0], pick_reg(), pick_reg()};
                    3:       return {10'h00d, f[11:0], pick_reg(), pick_reg()};
                    4:       return {10'h00e, f[11:0], pick_reg(), pick_reg()};
                    5:       return {10'h00f, f[11:0], pick_reg(), pick_reg()};
                    6:       return {17'h00081, f[4:0], pick_reg(), pick_reg()};
                    7:       return {17'h00089, f[4:0], pick_reg(), pick_reg()};
                    8:       return {17'h00091, f[4:0], pick_reg(), pick_reg()};
                    9:       return {7'h0a, f[19:0], pick_reg()};
                    default: return {7'h0e, f[19:0], pick_reg()};
                endcase
            end
            2:
            begin
                // b and bl carry a full 26-bit offset
                if ((idx % 9) inside {1, 2})
                    return {6'h13 + 6'(idx % 9), f[25:0]};
                return {6'h13 + 6'(idx % 9), f[15:0], pick_reg(), pick_reg()};
            end
            default:
            begin
                if (r[8])
                    return {1'b1, f[30:0]};
                return {17'h00021, f[14:0]};
            end
        endcase
    endfunction

    // writeback side, preload sweep then random writes
    always @(posedge clk)
    begin
        if (preload_addr != 5'd0)
        begin
            wb <= '{we: 1'b1, addr: preload_addr, data: $random(seed)};
            preload_addr <= preload_addr + 5'd1;
        end
        else if (wb_random)
        begin
            wb_bits = $random(seed);
            wb <= '{we: wb_bits[0] | wb_bits[1], addr: pick_reg(), data: $random(seed)};
        end
        else
        begin
            wb <= '0;
        end
    end

    // execute back-pressure
    always @(posedge clk)
    begin
        if (stall_random)
            es_allow_in <= (($random(seed) & 3) != 0);
        else
            es_allow_in <= 1'b1;
    end

    // mid-cycle compare, all signals settled
    always @(negedge clk)
    begin : compare
        fs_to_ds_t front;
        ds_to_es_t exp;
        br_t       exp_br;
        logic      stage_full;
        logic      allow_exp;
        exp_br = '0;
        // at most one instruction sits in the stage
        stage_full = (pending.size() != 0);
        allow_exp = !stage_full || es_allow_in;
        if (!reset)
        begin
            check("es_valid", stage_full, es_valid);
            check("ds_allow_in", allow_exp, ds_allow_in);
            if (stage_full && es_allow_in)
            begin
                front = pending.pop_front();
                transferred++;
                exp = expect_bundle(front.pc, front.inst, wb);
                exp_br = expect_branch(front.pc, front.inst, exp.rj_value, exp.rkd_value);
                check("pc order", exp.pc, es_bus.pc);
                check("rj_value", exp.rj_value, es_bus.rj_value);
                check("rkd_value", exp.rkd_value, es_bus.rkd_value);
                check("imm", exp.imm, es_bus.imm);
                check("dest", exp.dest, es_bus.dest);
                check("op", exp.op, es_bus.op);
            end
            check("br.taken", exp_br.taken, br.taken);
            if (exp_br.taken)
                check("br.target", exp_br.target, br.target);
            // a wrong-path offer in the taken cycle is not accepted
            if (fs_valid && allow_exp)
            begin
                if (exp_br.taken)
                    dropped++;
                else
                    pending.push_back(fs_bus);
            end
        end
        if (wb.we && (wb.addr != 5'd0))
            shadow[wb.addr] = wb.data;
    end

    // offer one instruction until decode can take it
    task automatic send(input word_t inst);
        int waited;
        waited = 0;
        @(posedge clk);
        fs_valid <= 1'b1;
        fs_bus <= '{pc: next_pc, inst: inst};
        next_pc = next_pc + 32'd4;
        @(negedge clk);
        while (!ds_allow_in)
        begin
            if (waited == wait_limit)
                report_error("timeout waiting for ds_allow_in with an instruction offered");
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        fs_valid <= 1'b0;
        @(negedge clk);
        while (es_valid || (pending.size() != 0))
        begin
            if (waited == wait_limit)
                report_error("timeout waiting for the stage to drain into execute");
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic run_group(input string name, input int group, input int count);
        test_name = name;
        for (int i = 0; i < count; i++)
        begin
            send(random_inst(group));
        end
        drain();
    endtask

    initial
    begin
        int waited;
        seed = seed_init;
        clk = 1'b0;
        reset = 1'b1;
        fs_valid = 1'b0;
        fs_bus = '0;
        next_pc = 32'h1c00_0000;
        test_name = "reset";
        waited = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("es_valid", 1'b0, es_valid);
        check("br.taken", 1'b0, br.taken);
        check("ds_allow_in", 1'b1, ds_allow_in);
        while (preload_addr != 5'd0)
        begin
            if (waited == wait_limit)
                report_error("timeout waiting for the register preload to finish");
            waited++;
            @(negedge clk);
        end
        wb_random = 1'b1;
        run_group("reg_alu", 0, 60);
        run_group("imm_alu", 1, 60);
        run_group("branch", 2, 80);
        run_group("invalid", 3, 20);
        stall_random = 1'b1;
        test_name = "backpressure";
        for (int i = 0; i < 160; i++)
        begin
            send(random_inst(i % 4));
        end
        drain();
        stall_random = 1'b0;
        @(negedge clk);
        if ((transferred > 0) && (dropped > 0))
        begin
            $display("test passed");
            $finish;
        end
        else
        begin
            report_error("no instruction reached execute or no wrong-path offer was dropped");
        end
    end

endmodule

// ==== logic/decode_stage.sv ====
module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      fs_valid,
    input  fs_to_ds_t fs_bus,
    output logic      ds_allow_in,
    output logic      es_valid,
    output ds_to_es_t es_bus,
    input  logic      es_allow_in,
    input  wb_t       wb,
    output br_t       br
);

    // held instruction and its valid bit
    fs_to_ds_t ds_bus;
    logic      ds_valid;

    // held instruction moves to execute this cycle
    logic      ds_go;
    logic      br_taken;

    dec_op_t   op;
    reg_addr_t rj;
    reg_addr_t rk_or_rd;
    reg_addr_t dest;
    word_t     imm;
    word_t     rj_value;
    word_t     rkd_value;
    logic      taken;
    word_t     target;

    // no internal stall source, only execute back-pressure
    assign ds_go       = ds_valid && es_allow_in;
    assign ds_allow_in = !ds_valid || es_allow_in;
    assign es_valid    = ds_valid;

    // redirect only on the transfer itself
    assign br_taken = ds_go && taken;

    // wrong-path instruction offered alongside a taken branch is dropped
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ds_valid <= 1'b0;
        end
        else if (br_taken)
        begin
            ds_valid <= 1'b0;
        end
        else if (ds_allow_in)
        begin
            ds_valid <= fs_valid;
        end
    end

    // payload only moves on accept, so it holds under back-pressure
    always_ff @(posedge clk)
    begin
        if (fs_valid && ds_allow_in && !br_taken)
        begin
            ds_bus <= fs_bus;
        end
    end

    inst_decoder u_decoder (
        .inst     (ds_bus.inst),
        .op       (op),
        .rj       (rj),
        .rk_or_rd (rk_or_rd),
        .dest     (dest),
        .imm      (imm)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (rk_or_rd),
        .wb     (wb),
        .rdata1 (rj_value),
        .rdata2 (rkd_value)
    );

    // offsets come straight from the instruction word
    branch_unit u_branch (
        .op        (op),
        .pc        (ds_bus.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .imm_offs  (ds_bus.inst),
        .taken     (taken),
        .target    (target)
    );

    assign es_bus = '{
        pc:        ds_bus.pc,
        rj_value:  rj_value,
        rkd_value: rkd_value,
        imm:       imm,
        dest:      dest,
        op:        op
    };

    assign br = '{taken: br_taken, target: target};

endmodule

// ==== logic/branch_unit.sv ====
module branch_unit
    import isa_pkg::*;
(
    input  dec_op_t op,
    input  word_t   pc,
    input  word_t   rj_value,
    input  word_t   rkd_value,
    // raw instruction word, offsets are cut from it here
    input  word_t   imm_offs,
    output logic    taken,
    output word_t   target
);

    logic [15:0] offs16;
    logic [25:0] offs26;
    word_t       offs16_ext;
    word_t       offs26_ext;
    logic        eq;
    logic        lt_s;
    logic        lt_u;

    // offs26 is split, high part at the bottom of the word
    assign offs16 = imm_offs[i16_lsb +: 16];
    assign offs26 = {imm_offs[i26_hi_lsb +: 10], imm_offs[i16_lsb +: 16]};

    // word offsets, sign extended
    assign offs16_ext = {{14{offs16[15]}}, offs16, 2'b00};
    assign offs26_ext = {{4{offs26[25]}}, offs26, 2'b00};

    assign eq   = (rj_value == rkd_value);
    assign lt_s = ($signed(rj_value) < $signed(rkd_value));
    assign lt_u = (rj_value < rkd_value);

    always_comb
    begin
        case (op.br_kind)
            br_beq:               taken = eq;
            br_bne:               taken = !eq;
            br_blt:               taken = lt_s;
            br_bge:               taken = !lt_s;
            br_bltu:              taken = lt_u;
            br_bgeu:              taken = !lt_u;
            // unconditional
            br_b, br_bl, br_jirl: taken = 1'b1;
            default:              taken = 1'b0;
        endcase
    end

    // jirl is register relative, everything else pc relative
    always_comb
    begin
        case (op.br_kind)
            br_jirl:     target = rj_value + offs16_ext;
            br_b, br_bl: target = pc + offs26_ext;
            default:     target = pc + offs16_ext;
        endcase
    end

endmodule

// ==== logic/reg_file.sv ====
module reg_file
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  wb_t       wb,
    output word_t     rdata1,
    output word_t     rdata2
);

    // one word per architectural register
    word_t regs [2**$bits(reg_addr_t)];
    logic  wr_en;

    // r0 is hard-wired to zero, writes to it are dropped
    assign wr_en = wb.we && (wb.addr != '0);

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            regs[wb.addr] <= wb.data;
        end
    end

    // same-cycle write bypassed so decode sees the new value
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0)
        begin
            data = '0;
        end
        else if (wr_en && (addr == wb.addr))
        begin
            data = wb.data;
        end
        else
        begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb
    begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

// ==== logic/inst_decoder.sv ====
module inst_decoder
    import isa_pkg::*;
(
    input  word_t     inst,
    output dec_op_t   op,
    output reg_addr_t rj,
    output reg_addr_t rk_or_rd,
    output reg_addr_t dest,
    output word_t     imm
);

    // opcode slices
    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    reg_addr_t   rd;
    reg_addr_t   rk;
    logic [11:0] i12;
    logic [19:0] i20;

    // shared prefix of the three-register and shift-immediate groups
    logic grp_reg;
    logic grp_shift;

    // register-register alu
    logic inst_add_w;
    logic inst_sub_w;
    logic inst_slt;
    logic inst_sltu;
    logic inst_nor;
    logic inst_and;
    logic inst_or;
    logic inst_xor;
    logic inst_sll_w;
    logic inst_srl_w;
    logic inst_sra_w;

    // immediate alu
    logic inst_slli_w;
    logic inst_srli_w;
    logic inst_srai_w;
    logic inst_addi_w;
    logic inst_slti;
    logic inst_sltui;
    logic inst_andi;
    logic inst_ori;
    logic inst_xori;
    logic inst_lu12i_w;
    logic inst_pcaddu12i;

    // control flow
    logic inst_beq;
    logic inst_bne;
    logic inst_blt;
    logic inst_bge;
    logic inst_bltu;
    logic inst_bgeu;
    logic inst_b;
    logic inst_bl;
    logic inst_jirl;

    logic is_cond_br;
    logic ine;

    // immediate kinds
    logic imm_is_4;
    logic need_ui5;
    logic need_si12;
    logic need_ui12;
    logic need_si20;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign rd  = inst[rd_lsb +: 5];
    assign rj  = inst[rj_lsb +: 5];
    assign rk  = inst[rk_lsb +: 5];
    assign i12 = inst[i12_lsb +: 12];
    assign i20 = inst[i20_lsb +: 20];

    assign grp_reg   = (op6 == op6_alu) && (op4 == op4_reg) && (op2 == op2_reg);
    assign grp_shift = (op6 == op6_alu) && (op4 == op4_shift_imm) && (op2 == op2_shift_imm);

    assign inst_add_w = grp_reg && (op5 == op5_add);
    assign inst_sub_w = grp_reg && (op5 == op5_sub);
    assign inst_slt   = grp_reg && (op5 == op5_slt);
    assign inst_sltu  = grp_reg && (op5 == op5_sltu);
    assign inst_nor   = grp_reg && (op5 == op5_nor);
    assign inst_and   = grp_reg && (op5 == op5_and);
    assign inst_or    = grp_reg && (op5 == op5_or);
    assign inst_xor   = grp_reg && (op5 == op5_xor);
    assign inst_sll_w = grp_reg && (op5 == op5_sll);
    assign inst_srl_w = grp_reg && (op5 == op5_srl);
    assign inst_sra_w = grp_reg && (op5 == op5_sra);

    assign inst_slli_w = grp_shift && (op5 == op5_slli);
    assign inst_srli_w = grp_shift && (op5 == op5_srli);
    assign inst_srai_w = grp_shift && (op5 == op5_srai);

    // 12-bit immediate forms only need op[31:22]
    assign inst_addi_w = (op6 == op6_alu) && (op4 == op4_addi);
    assign inst_slti   = (op6 == op6_alu) && (op4 == op4_slti);
    assign inst_sltui  = (op6 == op6_alu) && (op4 == op4_sltui);
    assign inst_andi   = (op6 == op6_alu) && (op4 == op4_andi);
    assign inst_ori    = (op6 == op6_alu) && (op4 == op4_ori);
    assign inst_xori   = (op6 == op6_alu) && (op4 == op4_xori);

    // 20-bit forms need inst[25] clear
    assign inst_lu12i_w   = (op6 == op6_lu12i) && !op4[3];
    assign inst_pcaddu12i = (op6 == op6_pcaddu12i) && !op4[3];

    assign inst_beq  = (op6 == op6_beq);
    assign inst_bne  = (op6 == op6_bne);
    assign inst_blt  = (op6 == op6_blt);
    assign inst_bge  = (op6 == op6_bge);
    assign inst_bltu = (op6 == op6_bltu);
    assign inst_bgeu = (op6 == op6_bgeu);
    assign inst_b    = (op6 == op6_b);
    assign inst_bl   = (op6 == op6_bl);
    assign inst_jirl = (op6 == op6_jirl);

    assign is_cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

    // anything outside the kept set
    assign ine = ~(grp_reg & (inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor
                              | inst_and | inst_or | inst_xor | inst_sll_w | inst_srl_w
                              | inst_sra_w)
                   | inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w | inst_slti
                   | inst_sltui | inst_andi | inst_ori | inst_xori | inst_lu12i_w
                   | inst_pcaddu12i | is_cond_br | inst_b | inst_bl | inst_jirl);

    assign imm_is_4  = inst_bl | inst_jirl;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | inst_slti | inst_sltui;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;

    // link value for bl and jirl comes from pc + 4
    assign imm = imm_is_4  ? 32'd4
               : need_si20 ? {i20, 12'b0}
               : need_ui5  ? {27'b0, rk}
               : need_si12 ? {{20{i12[11]}}, i12}
               : need_ui12 ? {20'b0, i12}
               : 32'b0;

    // conditional branches compare rj against rd
    assign rk_or_rd = is_cond_br ? rd : rk;
    assign dest     = inst_bl ? 5'd1 : rd;

    always_comb
    begin
        op = '0;
        op.alu_op.add     = inst_add_w | inst_addi_w | inst_pcaddu12i | inst_bl | inst_jirl;
        op.alu_op.sub     = inst_sub_w;
        op.alu_op.slt     = inst_slt | inst_slti;
        op.alu_op.sltu    = inst_sltu | inst_sltui;
        op.alu_op.bit_and = inst_and | inst_andi;
        op.alu_op.bit_nor = inst_nor;
        op.alu_op.bit_or  = inst_or | inst_ori;
        op.alu_op.bit_xor = inst_xor | inst_xori;
        op.alu_op.sll     = inst_sll_w | inst_slli_w;
        op.alu_op.srl     = inst_srl_w | inst_srli_w;
        op.alu_op.sra     = inst_sra_w | inst_srai_w;
        op.alu_op.lui     = inst_lu12i_w;
        op.src1_is_pc     = inst_pcaddu12i | inst_bl | inst_jirl;
        op.src2_is_imm    = need_ui5 | need_si12 | need_ui12 | need_si20 | imm_is_4;
        // only bl and jirl among the branches write a link register
        op.gr_we          = ~ine & ~is_cond_br & ~inst_b;
        op.ine            = ine;
        // one-hot inputs, so the order here does not matter
        if (inst_beq)
            op.br_kind = br_beq;
        else if (inst_bne)
            op.br_kind = br_bne;
        else if (inst_blt)
            op.br_kind = br_blt;
        else if (inst_bge)
            op.br_kind = br_bge;
        else if (inst_bltu)
            op.br_kind = br_bltu;
        else if (inst_bgeu)
            op.br_kind = br_bgeu;
        else if (inst_b)
            op.br_kind = br_b;
        else if (inst_bl)
            op.br_kind = br_bl;
        else if (inst_jirl)
            op.br_kind = br_jirl;
        else
            op.br_kind = br_none;
    end

endmodule

// ==== logic/pipe_pkg.sv ====
package pipe_pkg;

    // word and operation types live with the isa
    import isa_pkg::*;

    // fetch to decode
    typedef struct packed {
        word_t pc;
        word_t inst;
    } fs_to_ds_t;

    // decode to execute
    typedef struct packed {
        word_t     pc;
        // first source, always rj
        word_t     rj_value;
        // second source, rk or rd for conditional branches
        word_t     rkd_value;
        word_t     imm;
        reg_addr_t dest;
        dec_op_t   op;
    } ds_to_es_t;

    // writeback into the register file
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    // redirect back to fetch
    typedef struct packed {
        logic  taken;
        word_t target;
    } br_t;

endpackage

// ==== logic/isa_pkg.sv ====
package isa_pkg;

    // machine word width, fixed by the encoding
    localparam int xlen_w = 32;

    typedef logic [4:0]        reg_addr_t;
    typedef logic [xlen_w-1:0] word_t;

    // lsb of each field in the instruction word
    localparam int rd_lsb     = 0;
    localparam int rj_lsb     = 5;
    localparam int rk_lsb     = 10;
    localparam int i12_lsb    = 10;
    localparam int i16_lsb    = 10;
    localparam int i20_lsb    = 5;
    // upper ten bits of offs26 sit at the bottom of the word
    localparam int i26_hi_lsb = 0;

    // inst[31:26]
    localparam logic [5:0] op6_alu       = 6'h00;
    localparam logic [5:0] op6_lu12i     = 6'h05;
    localparam logic [5:0] op6_pcaddu12i = 6'h07;
    localparam logic [5:0] op6_jirl      = 6'h13;
    localparam logic [5:0] op6_b         = 6'h14;
    localparam logic [5:0] op6_bl        = 6'h15;
    localparam logic [5:0] op6_beq       = 6'h16;
    localparam logic [5:0] op6_bne       = 6'h17;
    localparam logic [5:0] op6_blt       = 6'h18;
    localparam logic [5:0] op6_bge       = 6'h19;
    localparam logic [5:0] op6_bltu      = 6'h1a;
    localparam logic [5:0] op6_bgeu      = 6'h1b;

    // inst[25:22]
    localparam logic [3:0] op4_reg       = 4'h0;
    localparam logic [3:0] op4_shift_imm = 4'h1;
    localparam logic [3:0] op4_slti      = 4'h8;
    localparam logic [3:0] op4_sltui     = 4'h9;
    localparam logic [3:0] op4_addi      = 4'ha;
    localparam logic [3:0] op4_andi      = 4'hd;
    localparam logic [3:0] op4_ori       = 4'he;
    localparam logic [3:0] op4_xori      = 4'hf;

    // inst[21:20]
    localparam logic [1:0] op2_reg       = 2'h1;
    localparam logic [1:0] op2_shift_imm = 2'h0;

    // inst[19:15], register group then shift immediate group
    localparam logic [4:0] op5_add  = 5'h00;
    localparam logic [4:0] op5_sub  = 5'h02;
    localparam logic [4:0] op5_slt  = 5'h04;
    localparam logic [4:0] op5_sltu = 5'h05;
    localparam logic [4:0] op5_nor  = 5'h08;
    localparam logic [4:0] op5_and  = 5'h09;
    localparam logic [4:0] op5_or   = 5'h0a;
    localparam logic [4:0] op5_xor  = 5'h0b;
    localparam logic [4:0] op5_sll  = 5'h0e;
    localparam logic [4:0] op5_srl  = 5'h0f;
    localparam logic [4:0] op5_sra  = 5'h10;
    localparam logic [4:0] op5_slli = 5'h01;
    localparam logic [4:0] op5_srli = 5'h09;
    localparam logic [4:0] op5_srai = 5'h11;

    // one-hot alu op, add at bit 0 and lui at bit 11
    typedef struct packed {
        logic lui;
        logic sra;
        logic srl;
        logic sll;
        logic bit_xor;
        logic bit_or;
        logic bit_nor;
        logic bit_and;
        logic sltu;
        logic slt;
        logic sub;
        logic add;
    } alu_op_t;

    typedef enum logic [3:0] {
        br_none = 4'd0,
        br_beq  = 4'd1,
        br_bne  = 4'd2,
        br_blt  = 4'd3,
        br_bge  = 4'd4,
        br_bltu = 4'd5,
        br_bgeu = 4'd6,
        br_b    = 4'd7,
        br_bl   = 4'd8,
        br_jirl = 4'd9
    } br_kind_t;

    typedef struct packed {
        alu_op_t  alu_op;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     gr_we;
        br_kind_t br_kind;
        // invalid instruction
        logic     ine;
    } dec_op_t;

endpackage
